// File: vlog.f
common/ram_ext_pkg.sv
ram_ctrl/bank_select_reg.sv
ram_ctrl/mem_cycle_tracker.sv
ram_ctrl/block_mapper.sv
rtl/ram_ext_top.sv
bench/tb_ram_ext.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_ram_ext
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits with a failing status when the testbench stops on $fatal
run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_ram_ext.sv
// Testbench for the RAM expansion controller with random bus traffic and a reference model
// Runs a reset check and then one random test for each DIP setting

`timescale 1ns/1ps

module tb_ram_ext;

  localparam int unsigned cycles_per_test = 2000;
  localparam int unsigned random_tests    = 4;
  localparam int unsigned reset_checks    = 16;
  // Every test adds one lead-in edge and three reset edges to its own cycles
  localparam int unsigned total_cycles =
    random_tests * (cycles_per_test + 4) + reset_checks + 4;
  localparam int unsigned timeout_ns = total_cycles * 8 + 1000;

  logic                            clk;
  logic                            reset_b;
  logic                            rfsh_b;
  logic                            adr15;
  logic                            adr14;
  logic                            iorq_b;
  logic                            mreq_b;
  logic                            ramrd_b;
  logic                            wr_b;
  logic                            rd_b;
  logic                            m1_b;
  logic [7:0]                      data;
  logic [1:0]                      dip;
  logic                            ramdis;
  logic                            ramcs_b;
  logic                            ramoe_b;
  logic                            ramwe_b;
  logic                            rd_drive;
  logic                            adr15_drive;
  logic [ram_ext_pkg::adrhi_w-1:0] ramadrhi;

  // Reference model state, updated on every rising edge like the DUT registers
  ram_ext_pkg::bank_cfg_t m_cfg;
  logic                   m_mreq_q = 1'b1;
  logic                   m_mwr;
  logic                   m_lat;
  logic [31:0]            rng_state;
  string                  test_name;

  ram_ext_top i_ram_ext_top (
    .clk         (clk),
    .reset_b     (reset_b),
    .rfsh_b      (rfsh_b),
    .adr15       (adr15),
    .adr14       (adr14),
    .iorq_b      (iorq_b),
    .mreq_b      (mreq_b),
    .ramrd_b     (ramrd_b),
    .wr_b        (wr_b),
    .rd_b        (rd_b),
    .m1_b        (m1_b),
    .data        (data),
    .dip         (dip),
    .ramdis      (ramdis),
    .ramcs_b     (ramcs_b),
    .ramoe_b     (ramoe_b),
    .ramwe_b     (ramwe_b),
    .rd_drive    (rd_drive),
    .adr15_drive (adr15_drive),
    .ramadrhi    (ramadrhi)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Ends a run that stops making progress
  initial begin
    #(timeout_ns);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation timeout");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s expected %b actual %b", test_name, what, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic check_adrhi(input logic [ram_ext_pkg::adrhi_w-1:0] exp,
                             input logic [ram_ext_pkg::adrhi_w-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s ramadrhi expected %h actual %h", test_name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  // The stored configuration is read from inside the top level
  task automatic check_cfg_pins(input ram_ext_pkg::bank_cfg_t exp,
                                input ram_ext_pkg::bank_cfg_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s cfg expected %h actual %h", test_name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Called right after a rising edge, while the inputs still hold what the DUT sampled
  task automatic step_model();
    logic       fall;
    logic [2:0] b;
    if (!reset_b) begin
      m_cfg    = '0;
      m_mreq_q = 1'b1;
      m_mwr    = 1'b0;
      m_lat    = 1'b0;
    end else begin
      if (!iorq_b && !wr_b && !adr15 && (data[7:6] == 2'b11)) begin
        b = data[5:3];
        // Shadow bank 3 folds down to bank 2 when shadow mode is on
        if (dip[1] && (b == 3'd3)) begin
          b = 3'd2;
        end
        m_cfg.bank   = b;
        m_cfg.scheme = ram_ext_pkg::map_scheme_e'(data[2:0]);
        m_cfg.mode3  = (data[2:0] == 3'd3);
      end
      fall = m_mreq_q && !mreq_b;
      if (fall && rfsh_b && rd_b && m1_b) begin
        m_mwr = 1'b1;
      end else if (mreq_b) begin
        m_mwr = 1'b0;
      end
      if (fall) begin
        m_lat = adr15;
      end
      m_mreq_q = mreq_b;
    end
  endtask

  task automatic drive_idle();
    iorq_b  <= 1'b1;
    wr_b    <= 1'b1;
    mreq_b  <= 1'b1;
    rfsh_b  <= 1'b1;
    rd_b    <= 1'b1;
    m1_b    <= 1'b1;
    ramrd_b <= 1'b1;
    adr15   <= 1'b0;
    adr14   <= 1'b0;
    data    <= 8'h00;
  endtask

  // One eighth of the cycles are forced select writes, the rest are random bus levels
  // mreq_b toggles about every other cycle so that requests last a few clocks
  task automatic drive_random_cycle(input bit allow_sel);
    logic [31:0] r;
    draw_random(r);
    data    <= r[15:8];
    adr14   <= r[17];
    rfsh_b  <= (r[23:21] != 3'd0);
    m1_b    <= (r[26:24] != 3'd0);
    rd_b    <= r[27];
    ramrd_b <= r[28];
    if (allow_sel && (r[2:0] == 3'd0)) begin
      iorq_b <= 1'b0;
      wr_b   <= 1'b0;
      adr15  <= 1'b0;
      mreq_b <= 1'b1;
      data   <= {2'b11, r[13:8]};
    end else begin
      iorq_b <= allow_sel ? (r[3] | r[4]) : 1'b1;
      wr_b   <= r[5];
      adr15  <= r[16];
      mreq_b <= r[19] ? !mreq_b : mreq_b;
    end
  endtask

  // Outputs are compared on the falling edge, half a cycle after the inputs change
  task automatic check_outputs();
    logic [2:0]                      scheme;
    logic [1:0]                      quad;
    logic                            hit;
    logic [1:0]                      blk;
    logic                            cs_int;
    logic [ram_ext_pkg::adrhi_w-1:0] adrhi;
    scheme = m_cfg.scheme;
    quad = {((scheme == 3'd3) ? m_lat : adr15), adr14};
    hit  = 1'b0;
    blk  = 2'd3;
    case (scheme)
      3'd1, 3'd3: hit = (quad == 2'd3);
      3'd2: begin
        hit = 1'b1;
        blk = quad;
      end
      3'd4, 3'd5, 3'd6, 3'd7: begin
        hit = (quad == 2'd1);
        blk = 2'(scheme - 3'd4);
      end
      default: hit = 1'b0;
    endcase
    cs_int = 1'b1;
    adrhi  = '0;
    if (hit) begin
      cs_int = 1'b0;
      adrhi  = {m_cfg.bank, blk};
    end else if (dip[1]) begin
      cs_int = ((scheme == 3'd3) && (quad == 2'd1)) ? 1'b0 : !m_mwr;
      adrhi  = ((scheme == 3'd3) && (quad == 2'd1)) ? {3'd3, 2'd3} : {3'd3, quad};
    end
    check_cfg_pins(m_cfg, i_ram_ext_top.cfg);
    check_adrhi(adrhi, ramadrhi);
    check_bit("ramcs_b", cs_int | mreq_b | !rfsh_b, ramcs_b);
    check_bit("ramdis", !cs_int, ramdis);
    check_bit("ramoe_b", ramrd_b, ramoe_b);
    check_bit("ramwe_b", wr_b, ramwe_b);
    check_bit("rd_drive", dip[0] & hit & m_mwr, rd_drive);
    check_bit("adr15_drive", dip[0] & m_cfg.mode3 & adr14 & m_mwr, adr15_drive);
  endtask

  task automatic apply_reset(input logic [1:0] dip_val);
    @(posedge clk);
    step_model();
    reset_b <= 1'b0;
    dip     <= dip_val;
    drive_idle();
    repeat (3) begin
      @(posedge clk);
      step_model();
    end
    reset_b <= 1'b1;
  endtask

  task automatic run_cycle(input bit allow_sel);
    @(posedge clk);
    step_model();
    drive_random_cycle(allow_sel);
    @(negedge clk);
    check_outputs();
  endtask

  task automatic run_random_test(input string name, input logic [1:0] dip_val);
    test_name = name;
    apply_reset(dip_val);
    repeat (cycles_per_test) begin
      run_cycle(1'b1);
    end
  endtask

  initial begin
    rng_state = 32'h2151_2f85;
    reset_b   <= 1'b0;
    dip       <= 2'b00;
    drive_idle();

    // No select writes here, so the card must stay out of the way with overdrive on
    test_name = "reset_state";
    apply_reset(2'b01);
    repeat (reset_checks) begin
      run_cycle(1'b0);
      check_bit("ramcs_b", 1'b1, ramcs_b);
      check_bit("ramdis", 1'b0, ramdis);
      check_bit("rd_drive", 1'b0, rd_drive);
      check_bit("adr15_drive", 1'b0, adr15_drive);
    end

    run_random_test("plain", 2'b00);
    run_random_test("shadow", 2'b10);
    run_random_test("overdrive", 2'b01);
    run_random_test("shadow_overdrive", 2'b11);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: rtl/ram_ext_top.sv
// Top level of the 512K RAM expansion bank-switching controller
// Connects the select register, the cycle tracker and the mapper to the card pins

`timescale 1ns/1ps

module ram_ext_top (
  input  logic                              clk,
  input  logic                              reset_b,
  input  logic                              rfsh_b,
  input  logic                              adr15,
  input  logic                              adr14,
  input  logic                              iorq_b,
  input  logic                              mreq_b,
  input  logic                              ramrd_b,
  input  logic                              wr_b,
  input  logic                              rd_b,
  input  logic                              m1_b,
  input  logic [7:0]                        data,
  input  logic [1:0]                        dip,
  output logic                              ramdis,
  output logic                              ramcs_b,
  output logic                              ramoe_b,
  output logic                              ramwe_b,
  output logic                              rd_drive,
  output logic                              adr15_drive,
  output logic [ram_ext_pkg::adrhi_w-1:0]   ramadrhi
);

  logic                   overdrive_mode;
  logic                   shadow_mode;
  ram_ext_pkg::bank_cfg_t cfg;
  ram_ext_pkg::cycle_t    cyc;
  ram_ext_pkg::ram_ctrl_t ctrl;

  // Switch 1 selects 464 overdrive, switch 2 partial shadow RAM
  assign overdrive_mode = dip[0];
  assign shadow_mode    = dip[1];

  bank_select_reg i_bank_select_reg (
    .clk         (clk),
    .reset_b     (reset_b),
    .iorq_b      (iorq_b),
    .wr_b        (wr_b),
    .adr15       (adr15),
    .data        (data),
    .shadow_mode (shadow_mode),
    .cfg         (cfg)
  );

  mem_cycle_tracker i_mem_cycle_tracker (
    .clk     (clk),
    .reset_b (reset_b),
    .mreq_b  (mreq_b),
    .rfsh_b  (rfsh_b),
    .rd_b    (rd_b),
    .m1_b    (m1_b),
    .adr15   (adr15),
    .cyc     (cyc)
  );

  block_mapper i_block_mapper (
    .adr15       (adr15),
    .adr14       (adr14),
    .shadow_mode (shadow_mode),
    .cfg         (cfg),
    .cyc         (cyc),
    .ctrl        (ctrl)
  );

  // SRAM is selected only inside a real memory request and never during refresh
  assign ramcs_b  = ctrl.ramcs_int_b | mreq_b | !rfsh_b;
  // Internal RAM is disabled whenever the mapper wants the SRAM
  assign ramdis   = !ctrl.ramcs_int_b;
  assign ramadrhi = ctrl.ramadrhi;

  // Read and write strobes go straight to the SRAM
  assign ramoe_b = ramrd_b;
  assign ramwe_b = wr_b;

  // On the 464 the gate array still reads internal RAM, so rd_b is held low on
  // expansion writes only
  assign rd_drive = overdrive_mode & ctrl.exp_ram & cyc.mwr_cyc;

  // Mode 3 remaps 4000h to C000h by forcing address bit 15 high on writes
  assign adr15_drive = overdrive_mode & cfg.mode3 & adr14 & cyc.mwr_cyc;

endmodule

// File: ram_ctrl/block_mapper.sv
// Combinational map from bank configuration, cycle state and CPU address to SRAM controls
// Decides expansion hit, SRAM high address and shadow selection for every access

`timescale 1ns/1ps

module block_mapper (
  input  logic                   adr15,
  input  logic                   adr14,
  input  logic                   shadow_mode,
  input  ram_ext_pkg::bank_cfg_t cfg,
  input  ram_ext_pkg::cycle_t    cyc,
  output ram_ext_pkg::ram_ctrl_t ctrl
);

  logic [1:0]                     quad;
  logic                           hit;
  logic [ram_ext_pkg::blk_w-1:0]  blk;
  logic [2:0]                     scheme_val;
  logic                           is_c3;

  assign scheme_val = cfg.scheme;
  // Mode 3 comes pre-decoded from the select register
  assign is_c3      = cfg.mode3;

  // The CPU address quadrant selects the 16K block
  // Mode 3 uses the latched bit 15 because the card itself drives that pin mid-cycle
  assign quad = {(is_c3 ? cyc.adr15_lat : adr15), adr14};

  // Hit table per scheme
  always_comb begin
    hit = 1'b0;
    blk = '1;
    case (cfg.scheme)
      ram_ext_pkg::scheme_off: begin
        hit = 1'b0;
      end
      // Top quadrant only, always block 3
      ram_ext_pkg::scheme_top3,
      ram_ext_pkg::scheme_c3: begin
        hit = (quad == 2'd3);
        blk = '1;
      end
      // Whole 64K bank replaces internal RAM
      ram_ext_pkg::scheme_flat: begin
        hit = 1'b1;
        blk = quad;
      end
      // The 4000h window pages in one block of the bank
      // Schemes 4 to 7 carry the block number in their low bits
      ram_ext_pkg::scheme_mid0,
      ram_ext_pkg::scheme_mid1,
      ram_ext_pkg::scheme_mid2,
      ram_ext_pkg::scheme_mid3: begin
        hit = (quad == 2'd1);
        blk = scheme_val[ram_ext_pkg::blk_w-1:0];
      end
      default: begin
        hit = 1'b0;
      end
    endcase
  end

  // Outputs for hit, shadow miss and plain miss
  always_comb begin
    ctrl.exp_ram     = hit;
    ctrl.ramcs_int_b = 1'b1;
    ctrl.ramadrhi    = '0;
    ctrl.shadow_sel  = 1'b0;
    if (hit) begin
      ctrl.ramcs_int_b = 1'b0;
      ctrl.ramadrhi    = {cfg.bank, blk};
    end else if (shadow_mode) begin
      // Every miss in shadow mode points into the shadow bank
      ctrl.shadow_sel = 1'b1;
      if (is_c3 && (quad == 2'd1)) begin
        // Mode 3 reads quadrant 1 from shadow block 3, for reads and writes alike
        ctrl.ramcs_int_b = 1'b0;
        ctrl.ramadrhi    = {ram_ext_pkg::shadow_bank, 2'd3};
      end else begin
        // Writes are copied into the shadow bank while the internal RAM also takes them
        ctrl.ramcs_int_b = !cyc.mwr_cyc;
        ctrl.ramadrhi    = {ram_ext_pkg::shadow_bank, quad};
      end
    end
  end

endmodule

// File: ram_ctrl/mem_cycle_tracker.sv
// Tracks CPU memory write cycles and latches address bit 15 at the start of each access
// Feeds the mapper and the overdrive enables with the current cycle state

`timescale 1ns/1ps

module mem_cycle_tracker (
  input  logic                clk,
  input  logic                reset_b,
  input  logic                mreq_b,
  input  logic                rfsh_b,
  input  logic                rd_b,
  input  logic                m1_b,
  input  logic                adr15,
  output ram_ext_pkg::cycle_t cyc
);

  logic mreq_b_q;
  logic mreq_fall;
  logic wr_start;

  // A request starts when mreq_b was high on the last edge and is low now
  assign mreq_fall = mreq_b_q && !mreq_b;

  // Writes are what is left once refresh, opcode fetch and reads are excluded
  // rd_b is still high at the start of a write because wr_b comes later in T2
  assign wr_start = mreq_fall && rfsh_b && rd_b && m1_b;

  // Previous request level, idle high after reset so no false edge is seen
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      mreq_b_q <= 1'b1;
    end else begin
      mreq_b_q <= mreq_b;
    end
  end

  // Write-cycle flag is set by a qualifying fall and held until the request is released
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      cyc.mwr_cyc <= 1'b0;
    end else if (wr_start) begin
      cyc.mwr_cyc <= 1'b1;
    end else if (mreq_b) begin
      cyc.mwr_cyc <= 1'b0;
    end
  end

  // Mode 3 overdrives address bit 15 during the cycle, so the CPU value has to be
  // captured before that happens and kept until the next request begins
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      cyc.adr15_lat <= 1'b0;
    end else if (mreq_fall) begin
      cyc.adr15_lat <= adr15;
    end
  end

endmodule

// File: ram_ctrl/bank_select_reg.sv
// Bank configuration register, loaded by a CPU write to the bank-select I/O port
// Holds the bank, the block scheme and the pre-decoded mode-3 flag for the mapper

`timescale 1ns/1ps

module bank_select_reg (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic                   iorq_b,
  input  logic                   wr_b,
  input  logic                   adr15,
  input  logic [7:0]             data,
  input  logic                   shadow_mode,
  output ram_ext_pkg::bank_cfg_t cfg
);

  logic                          sel_wr;
  logic [ram_ext_pkg::bank_w-1:0] bank_nxt;

  // The port sits in the lower half of I/O space with the top two data bits as its tag
  // Both strobes are sampled on the rising edge rather than used as a clock
  assign sel_wr = !iorq_b && !wr_b && !adr15 && (data[7:6] == ram_ext_pkg::sel_tag);

  // Data bits 5:3 carry the bank number
  // In shadow mode the shadow bank is aliased down by clearing its low bit,
  // so the CPU can never select the bank that shadows internal RAM
  always_comb begin
    bank_nxt = data[3 +: ram_ext_pkg::bank_w];
    if (shadow_mode && (bank_nxt == ram_ext_pkg::shadow_bank)) begin
      bank_nxt[0] = 1'b0;
    end
  end

  // Configuration changes only on a select write and is visible on the next cycle
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      // Bank 0 with switching off, so every access uses internal RAM
      cfg <= '0;
    end else if (sel_wr) begin
      cfg.bank   <= bank_nxt;
      cfg.scheme <= ram_ext_pkg::map_scheme_e'(data[2:0]);
      // Mode 3 is the only scheme that needs address bit 15 latched and overdriven
      cfg.mode3  <= (data[2:0] == ram_ext_pkg::scheme_c3);
    end
  end

endmodule

// File: common/ram_ext_pkg.sv
// Shared widths, constants, scheme encoding and bundle types for the RAM expansion controller
// Referenced by scoped name from every block of the bank-switching logic

package ram_ext_pkg;

  // Width of the 64K bank number picked by a select write
  localparam int unsigned bank_w = 3;

  // Width of the 16K block number inside a bank
  localparam int unsigned blk_w = 2;

  // SRAM high address is the bank followed by the block
  localparam int unsigned adrhi_w = bank_w + blk_w;

  // Bank reserved for shadow RAM in partial shadow mode
  localparam logic [bank_w-1:0] shadow_bank = 3'd3;

  // Data bits 7:6 of an I/O write carry this tag for a bank select
  localparam logic [1:0] sel_tag = 2'b11;

  // Block switching schemes, taken from data bits 2:0 of the select write
  // Each one decides which CPU quadrants land in the expansion SRAM
  typedef enum logic [2:0] {
    scheme_off  = 3'd0,  // All accesses stay in internal RAM
    scheme_top3 = 3'd1,  // Quadrant 3 goes to block 3
    scheme_flat = 3'd2,  // All four quadrants map straight through
    scheme_c3   = 3'd3,  // Quadrant 3 to block 3, quadrant 1 remapped in shadow mode
    scheme_mid0 = 3'd4,  // Quadrant 1 goes to block 0
    scheme_mid1 = 3'd5,  // Quadrant 1 goes to block 1
    scheme_mid2 = 3'd6,  // Quadrant 1 goes to block 2
    scheme_mid3 = 3'd7   // Quadrant 1 goes to block 3
  } map_scheme_e;

  // Stored bank configuration
  // The mode3 flag is decoded at write time to keep the mapper path short
  typedef struct packed {
    logic [bank_w-1:0] bank;
    map_scheme_e       scheme;
    logic              mode3;
  } bank_cfg_t;

  // State of the current CPU memory cycle
  typedef struct packed {
    logic mwr_cyc;    // Memory write cycle in progress
    logic adr15_lat;  // Address bit 15 as seen when the request started
  } cycle_t;

  // Raw SRAM controls from the mapper, before strobe qualification
  typedef struct packed {
    logic               ramcs_int_b;
    logic               exp_ram;
    logic [adrhi_w-1:0] ramadrhi;
    logic               shadow_sel;
  } ram_ctrl_t;

endpackage
